// File: logic/obj_pkg.sv
// Object engine package: table layout, scanner states and stage structs
`default_nettype none

package obj_pkg;

    // Table and line limits
    localparam int obj_count     = 24;
    localparam int obj_line_max  = 24;
    localparam int obj_x_min     = 24;
    localparam int obj_height    = 16;
    localparam int draw_x_offset = 6;

    // Word address width of the table, two 16-bit words per entry
    localparam int table_aw = 6;

    typedef enum logic [1:0] {
        idle,
        read_a,
        read_b,
        settle
    } scan_state_e;

    // Byte order in the table is attr, x, inverted y, code
    typedef struct packed {
        logic [7:0] code;
        logic [7:0] y_n;
        logic [7:0] x;
        logic [7:0] attr;
    } obj_entry_t;

    typedef struct packed {
        logic [7:0] code;
        logic [3:0] row;
        logic [7:0] x;
        logic [3:0] bank;
        logic       hflip;
        logic       vflip;
    } draw_req_t;

    // Bank only matters ahead of the palette
    typedef struct packed {
        logic [7:0] addr;
        logic [3:0] bank;
        logic [3:0] colour;
        logic       valid;
    } pxl_wr_t;

endpackage

`default_nettype wire

// File: logic/obj_table_ram.sv
// Object table RAM with CPU byte port and 16-bit scan read port
`default_nettype none

module obj_table_ram
    import obj_pkg::*;
(
    input  wire                   clk,
    input  wire [table_aw:0]      cpu_addr,
    input  wire [7:0]             cpu_din,
    input  wire                   cpu_cs,
    input  wire                   cpu_rnw,
    output logic [7:0]            obj_dout,
    input  wire [table_aw-1:0]    scan_addr,
    output logic [15:0]           scan_word
);

    localparam int depth = 2 ** table_aw;

    // Even byte addresses land in the low bank, odd in the high bank
    logic [7:0] lo_mem [0:depth-1];
    logic [7:0] hi_mem [0:depth-1];

    logic [table_aw-1:0] cpu_word;
    logic                cpu_we;

    assign cpu_word = cpu_addr[table_aw:1];
    assign cpu_we   = cpu_cs && !cpu_rnw;

    always_ff @(posedge clk) begin
        if (cpu_we && !cpu_addr[0]) begin
            lo_mem[cpu_word] <= cpu_din;
        end
        if (cpu_we && cpu_addr[0]) begin
            hi_mem[cpu_word] <= cpu_din;
        end
    end

    // Readback one cycle after the address
    always_ff @(posedge clk) begin
        obj_dout <= cpu_addr[0] ? hi_mem[cpu_word] : lo_mem[cpu_word];
    end

    always_ff @(posedge clk) begin
        scan_word <= {hi_mem[scan_addr], lo_mem[scan_addr]};
    end

endmodule

`default_nettype wire

// File: logic/obj_scan.sv
// Per-line object table scanner issuing draw requests
`default_nettype none

module obj_scan
    import obj_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   hinit,
    input  wire [7:0]             vrender,
    output logic                  cen2,
    output logic [table_aw-1:0]   scan_addr,
    input  wire [15:0]            scan_word,
    input  wire                   draw_busy,
    output logic                  draw_start,
    output draw_req_t             draw_req
);

    localparam int drawn_w = $clog2(obj_line_max + 1);

    scan_state_e        state;
    logic               hinit_l;
    logic [drawn_w-1:0] drawn;
    logic [15:0]        word0_q;
    obj_entry_t         ent;
    logic [7:0]         y;
    logic [7:0]         diff;
    logic               last;
    logic               visible;

    // Second word arrives on scan_word while the first is held
    assign ent     = {scan_word, word0_q};
    assign y       = ~ent.y_n;
    assign diff    = vrender - y - 8'd1;
    assign last    = scan_addr[table_aw-1:1] == (table_aw-1)'(obj_count - 1);
    assign visible = diff < obj_height && ent.x > obj_x_min && drawn < obj_line_max;

    // Half-rate enable and hinit catch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen2    <= 1'b0;
            hinit_l <= 1'b0;
        end else begin
            cen2 <= ~cen2;
            if (hinit) begin
                hinit_l <= 1'b1;
            end else if (cen2) begin
                hinit_l <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= idle;
            scan_addr  <= '0;
            drawn      <= '0;
            draw_start <= 1'b0;
        end else begin
            draw_start <= 1'b0;
            if (cen2) begin
                case (state)
                    idle: if (hinit_l) begin
                        scan_addr <= '0;
                        drawn     <= '0;
                        state     <= read_a;
                    end
                    read_a: if (!draw_busy) begin
                        scan_addr <= scan_addr + 1'b1;
                        state     <= read_b;
                    end
                    read_b: begin
                        scan_addr <= scan_addr + 1'b1;
                        if (visible) begin
                            draw_start <= 1'b1;
                            drawn      <= drawn + 1'b1;
                        end
                        state <= last ? idle : settle;
                    end
                    // Lets draw_busy rise before the next entry
                    settle: state <= read_a;
                    default: state <= idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen2 && state == read_a && !draw_busy) begin
            word0_q <= scan_word;
        end
        if (cen2 && state == read_b) begin
            draw_req.code  <= ent.code;
            draw_req.row   <= diff[3:0];
            draw_req.x     <= ent.x;
            draw_req.bank  <= ent.attr[3:0];
            draw_req.hflip <= ent.attr[6];
            draw_req.vflip <= ent.attr[7];
        end
    end

endmodule

`default_nettype wire

// File: logic/obj_draw.sv
// Sprite drawer fetching ROM words and streaming pixel writes
`default_nettype none

module obj_draw
    import obj_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire          cen2,
    input  wire          draw_start,
    input  draw_req_t    draw_req,
    output logic         draw_busy,
    output logic [12:0]  rom_addr,
    output logic         rom_cs,
    input  wire [31:0]   rom_data,
    input  wire          rom_ok,
    output pxl_wr_t      pix_wr
);

    draw_req_t   req_q;
    logic        half;
    logic [2:0]  pix_cnt;
    logic [31:0] pxl_data;
    logic [7:0]  buf_a;
    logic [7:0]  start_a;
    logic        start;
    logic        fetch_done;
    logic        shift;

    logic        pix_valid;
    logic [7:0]  pix_addr;
    logic [3:0]  pix_bank;
    logic [3:0]  pix_colour;

    assign start      = draw_start && !draw_busy;
    assign fetch_done = rom_cs && rom_ok;
    assign shift      = draw_busy && !rom_cs && cen2;

    // Row is mirrored for vflip, half selects the word
    assign rom_addr = {req_q.code, req_q.row ^ {4{req_q.vflip}}, half};

    // Leftmost pixel, or rightmost when mirrored
    assign start_a = draw_req.hflip ? draw_req.x + 8'(draw_x_offset + obj_height - 1)
                                    : draw_req.x + 8'(draw_x_offset);

    assign pix_wr = '{addr: pix_addr, bank: pix_bank, colour: pix_colour, valid: pix_valid};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            draw_busy <= 1'b0;
            rom_cs    <= 1'b0;
            half      <= 1'b0;
            pix_cnt   <= 3'd0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            if (start) begin
                draw_busy <= 1'b1;
                rom_cs    <= 1'b1;
                half      <= 1'b0;
            end else if (rom_cs) begin
                if (rom_ok) begin
                    rom_cs  <= 1'b0;
                    pix_cnt <= 3'd0;
                end
            end else if (shift) begin
                pix_valid <= 1'b1;
                pix_cnt   <= pix_cnt + 3'd1;
                if (pix_cnt == 3'd7) begin
                    if (half) begin
                        draw_busy <= 1'b0;
                    end else begin
                        half   <= 1'b1;
                        rom_cs <= 1'b1;
                    end
                end
            end
        end
    end

    // Nibble k of a word is pixel k
    always_ff @(posedge clk) begin
        if (start) begin
            req_q <= draw_req;
            buf_a <= start_a;
        end else if (fetch_done) begin
            pxl_data <= rom_data;
        end else if (shift) begin
            pxl_data   <= pxl_data >> 4;
            buf_a      <= req_q.hflip ? buf_a - 8'd1 : buf_a + 8'd1;
            pix_addr   <= buf_a;
            pix_bank   <= req_q.bank;
            pix_colour <= pxl_data[3:0];
        end
    end

endmodule

`default_nettype wire

// File: logic/obj_palette.sv
// Writable colour PROM between drawer and line buffer
`default_nettype none

module obj_palette
    import obj_pkg::*;
(
    input  wire         clk,
    input  wire [7:0]   prog_addr,
    input  wire [3:0]   prog_data,
    input  wire         prog_en,
    input  pxl_wr_t     pix_wr,
    output pxl_wr_t     buf_wr
);

    logic [3:0] prom [0:255];
    logic [7:0] pal_addr;
    logic [3:0] pal_q;

    assign pal_addr = {pix_wr.bank, pix_wr.colour};
    assign pal_q    = prom[pal_addr];

    always_ff @(posedge clk) begin
        if (prog_en) begin
            prom[prog_addr] <= prog_data;
        end
    end

    // Colour 0 is transparent and never reaches the buffer
    always_ff @(posedge clk) begin
        buf_wr.addr   <= pix_wr.addr;
        buf_wr.bank   <= pix_wr.bank;
        buf_wr.colour <= pal_q;
        buf_wr.valid  <= pix_wr.valid && pal_q != 4'd0;
    end

endmodule

`default_nettype wire

// File: logic/obj_line_buffer.sv
// Double line buffer with erase after read
`default_nettype none

module obj_line_buffer
    import obj_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         hinit,
    input  wire         LHBL,
    input  wire         pxl_cen,
    input  pxl_wr_t     buf_wr,
    input  wire [7:0]   hdump,
    output logic [3:0]  pxl
);

    // Half wr_half is filled for the next line, the other is shown
    logic [3:0] mem [0:1][0:255];
    logic       wr_half;
    logic       rd_half;
    logic       erase;

    assign rd_half = ~wr_half;
    assign erase   = pxl_cen && LHBL;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_half <= 1'b0;
        end else if (hinit) begin
            wr_half <= ~wr_half;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_wr.valid) begin
            mem[wr_half][buf_wr.addr] <= buf_wr.colour;
        end
        // Cleared right after it is read so the half starts blank
        if (erase) begin
            mem[rd_half][hdump] <= 4'd0;
        end
    end

    always_ff @(posedge clk) begin
        pxl <= mem[rd_half][hdump];
    end

endmodule

`default_nettype wire

// File: logic/obj_engine.sv
// Sprite engine top level: table, scanner, drawer, palette and line buffer
`default_nettype none

module obj_engine
    import obj_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,

    // CPU port
    input  wire [table_aw:0]    cpu_addr,
    input  wire [7:0]           cpu_din,
    input  wire                 cpu_cs,
    input  wire                 cpu_rnw,
    output logic [7:0]          obj_dout,

    // Video timing
    input  wire                 hinit,
    input  wire                 LHBL,
    input  wire                 pxl_cen,
    input  wire [7:0]           hdump,
    input  wire [7:0]           vrender,

    // Colour PROM load
    input  wire [7:0]           prog_addr,
    input  wire [3:0]           prog_data,
    input  wire                 prog_en,

    // Graphics ROM
    output logic [12:0]         rom_addr,
    output logic                rom_cs,
    input  wire [31:0]          rom_data,
    input  wire                 rom_ok,

    output logic [3:0]          pxl
);

    logic [table_aw-1:0] scan_addr;
    logic [15:0]         scan_word;
    logic                cen2;
    logic                draw_busy;
    logic                draw_start;
    draw_req_t           draw_req;
    pxl_wr_t             pix_wr;
    pxl_wr_t             buf_wr;

    obj_table_ram u_table (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_din),
        .cpu_cs    (cpu_cs),
        .cpu_rnw   (cpu_rnw),
        .obj_dout  (obj_dout),
        .scan_addr (scan_addr),
        .scan_word (scan_word)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .hinit      (hinit),
        .vrender    (vrender),
        .cen2       (cen2),
        .scan_addr  (scan_addr),
        .scan_word  (scan_word),
        .draw_busy  (draw_busy),
        .draw_start (draw_start),
        .draw_req   (draw_req)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .cen2       (cen2),
        .draw_start (draw_start),
        .draw_req   (draw_req),
        .draw_busy  (draw_busy),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .pix_wr     (pix_wr)
    );

    obj_palette u_palette (
        .clk       (clk),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .pix_wr    (pix_wr),
        .buf_wr    (buf_wr)
    );

    obj_line_buffer u_buffer (
        .clk     (clk),
        .rst     (rst),
        .hinit   (hinit),
        .LHBL    (LHBL),
        .pxl_cen (pxl_cen),
        .buf_wr  (buf_wr),
        .hdump   (hdump),
        .pxl     (pxl)
    );

endmodule

`default_nettype wire

// File: tests/obj_engine_sva.sv
// Bound assertions on the graphics ROM request and the reset state of obj_engine
`default_nettype none

module obj_engine_sva (
    input wire        clk,
    input wire        rst,
    input wire        draw_start,
    input wire        draw_busy,
    input wire        rom_cs,
    input wire        rom_ok,
    input wire [12:0] rom_addr
);

    timeunit 1ns;
    timeprecision 100ps;

    // Raised by any failing assertion below
    bit   fail_seen = 1'b0;
    logic sprite_seen;

    // Set by the first draw request after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sprite_seen <= 1'b0;
        end else if (draw_start) begin
            sprite_seen <= 1'b1;
        end
    end

    // Reset values must still hold on the first clock after release
    reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !rom_cs && !draw_busy && !draw_start)
        else begin
            fail_seen = 1'b1;
            $error("drawer or ROM request active right after reset");
        end

    // No ROM traffic before a sprite has been selected
    no_early_fetch: assert property (@(posedge clk) disable iff (rst) !sprite_seen |-> !rom_cs)
        else begin
            fail_seen = 1'b1;
            $error("rom_cs raised before any sprite was selected");
        end

    req_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else begin
            fail_seen = 1'b1;
            $error("ROM request dropped or address changed before rom_ok");
        end

    start_when_free: assert property (@(posedge clk) disable iff (rst) draw_start |-> !draw_busy)
        else begin
            fail_seen = 1'b1;
            $error("draw request issued while the drawer was busy");
        end

endmodule

bind obj_engine obj_engine_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .draw_start (draw_start),
    .draw_busy  (draw_busy),
    .rom_cs     (rom_cs),
    .rom_ok     (rom_ok),
    .rom_addr   (rom_addr)
);

`default_nettype wire

// File: tests/obj_engine_tb.sv
// Sprite engine testbench: video timing, CPU, PROM and ROM models, reference model and checks
`default_nettype none

module obj_engine_tb
    import obj_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int line_cycles = 384;
    localparam int gap_cycles  = 32;
    localparam int lhbl_end    = 176;
    localparam int max_lines   = 24;
    localparam int watchdog_ns = (600 + max_lines * (line_cycles + gap_cycles)) * 10 * 2;

    logic              clk       = 1'b0;
    logic              rst       = 1'b0;
    logic [table_aw:0] cpu_addr  = '0;
    logic [7:0]        cpu_din   = '0;
    logic              cpu_cs    = 1'b0;
    logic              cpu_rnw   = 1'b1;
    logic [7:0]        obj_dout;
    logic              hinit     = 1'b0;
    logic              LHBL      = 1'b0;
    logic              pxl_cen   = 1'b0;
    logic [7:0]        hdump     = '0;
    logic [7:0]        vrender   = '0;
    logic [7:0]        prog_addr = '0;
    logic [3:0]        prog_data = '0;
    logic              prog_en   = 1'b0;
    logic [12:0]       rom_addr;
    logic              rom_cs;
    logic [31:0]       rom_data  = '0;
    logic              rom_ok    = 1'b0;
    logic [3:0]        pxl;

    logic [7:0] shadow [0:4*obj_count-1];
    logic [3:0] expect_line [0:255];
    logic [3:0] next_line [0:255];
    integer     seed     = 32'heb8b4d94;
    integer     rom_wait = -1;

    obj_engine dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] rom_word(input logic [12:0] a);
        rom_word = {a, a[5:0], a} * 32'h9e3779b1;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Graphics ROM answers 0 to 5 cycles after the request
    always @(posedge clk) begin
        #1;
        if (!rom_cs || rom_ok) begin
            rom_ok   = 1'b0;
            rom_wait = -1;
        end else begin
            if (rom_wait < 0) begin
                rom_wait = $unsigned($random(seed)) % 6;
            end
            if (rom_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(rom_addr);
            end else begin
                rom_wait = rom_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (dut.u_sva.fail_seen) begin
            abort_run("a bound assertion on obj_engine failed");
        end
    end

    initial begin
        #(watchdog_ns);
        abort_run("watchdog timeout, the lines did not complete in time");
    end

    task automatic cpu_write(input int a, input logic [7:0] d);
        cpu_addr  = (table_aw + 1)'(a);
        cpu_din   = d;
        cpu_cs    = 1'b1;
        cpu_rnw   = 1'b0;
        tick();
        cpu_cs    = 1'b0;
        cpu_rnw   = 1'b1;
        shadow[a] = d;
    endtask

    task automatic cpu_check(input int a);
        cpu_addr = (table_aw + 1)'(a);
        cpu_cs   = 1'b1;
        tick();
        assert (obj_dout === shadow[a]) else begin
            abort_run($sformatf("error %0t obj_dout at byte %0d: got %h expected %h",
                                $time, a, obj_dout, shadow[a]));
        end
        cpu_cs = 1'b0;
    endtask

    // Byte order of an entry is attr, x, inverted y, code
    task automatic set_sprite(input int i, input logic [7:0] y, input logic [7:0] x,
                              input logic [7:0] attr, input logic [7:0] code);
        cpu_write(4 * i, attr);
        cpu_write(4 * i + 1, x);
        cpu_write(4 * i + 2, ~y);
        cpu_write(4 * i + 3, code);
    endtask

    // Reference buffer for the line after a scan at vr
    task automatic build_line(input logic [7:0] vr);
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] attr;
        logic [7:0] row;
        logic [7:0] a;
        logic [3:0] r;
        logic [3:0] nib;
        int         drawn;
        int         i;
        int         k;
        drawn = 0;
        for (i = 0; i < 256; i++) begin
            next_line[i] = 4'd0;
        end
        for (i = 0; i < obj_count; i++) begin
            attr = shadow[4 * i];
            x    = shadow[4 * i + 1];
            y    = ~shadow[4 * i + 2];
            row  = vr - y - 8'd1;
            if (row < obj_height && x > obj_x_min && drawn < obj_line_max) begin
                drawn++;
                r = attr[7] ? ~row[3:0] : row[3:0];
                for (k = 0; k < 16; k++) begin
                    nib = 4'(rom_word({shadow[4 * i + 3], r, k[3]}) >> (4 * (k % 8)));
                    a   = attr[6] ? 8'(x + draw_x_offset + obj_height - 1 - k)
                                  : 8'(x + draw_x_offset + k);
                    // Palette holds bank XOR pixel, zero is transparent
                    if ((nib ^ attr[3:0]) != 4'd0) begin
                        next_line[a] = nib ^ attr[3:0];
                    end
                end
            end
        end
    endtask

    task automatic run_line(input logic [7:0] vr, input bit check);
        int h;
        for (h = 0; h < 256; h++) begin
            expect_line[h] = next_line[h];
        end
        build_line(vr);
        for (h = 0; h < line_cycles; h++) begin
            hinit   = h == 0;
            hdump   = 8'(h / 2);
            pxl_cen = h % 2 == 1;
            LHBL    = hdump < lhbl_end;
            vrender = vr;
            tick();
            if (check && pxl_cen && LHBL) begin
                assert (pxl === expect_line[hdump]) else begin
                    abort_run($sformatf("error %0t pxl at hdump %0d: got %h expected %h",
                                        $time, hdump, pxl, expect_line[hdump]));
                end
            end
        end
        hinit   = 1'b0;
        pxl_cen = 1'b0;
        LHBL    = 1'b0;
        repeat (gap_cycles) tick();
    endtask

    initial begin
        int a;
        int v;
        #1 rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (a = 0; a < 256; a++) begin
            prog_addr = 8'(a);
            prog_data = prog_addr[7:4] ^ prog_addr[3:0];
            prog_en   = 1'b1;
            tick();
        end
        prog_en = 1'b0;
        // Fill the table with entries hidden by x
        for (a = 0; a < obj_count; a++) begin
            set_sprite(a, 8'(a * 9), 8'(a), 8'(a * 37), 8'(a * 11 + 3));
        end
        for (a = 0; a < 4 * obj_count; a++) begin
            cpu_check(a);
        end
        // Both halves are blank only after one read each
        run_line(8'd50, 1'b0);
        run_line(8'd50, 1'b0);
        set_sprite(0, 40, 60, 8'h03, 8'h12);
        set_sprite(1, 45, 70, 8'h45, 8'h3c);
        set_sprite(2, 38, 120, 8'hc9, 8'h81);
        set_sprite(3, 44, 24, 8'h02, 8'h20);
        set_sprite(4, 33, 130, 8'h87, 8'h21);
        set_sprite(5, 50, 140, 8'h06, 8'h22);
        for (a = 0; a < 24; a++) begin
            cpu_check(a);
        end
        for (v = 34; v <= 66; v += 2) begin
            run_line(8'(v), 1'b1);
        end
        // Lines with no sprite left in range
        run_line(8'd200, 1'b1);
        run_line(8'd200, 1'b1);
        if (dut.u_sva.fail_seen) begin
            abort_run("a bound assertion on obj_engine failed during the run");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
logic/obj_pkg.sv
logic/obj_table_ram.sv
logic/obj_scan.sv
logic/obj_draw.sv
logic/obj_palette.sv
logic/obj_line_buffer.sv
logic/obj_engine.sv
tests/obj_engine_sva.sv
tests/obj_engine_tb.sv
